// File: fp_pkg.sv
package fp_pkg;

  // signed Q16.16 format
  localparam int NUM_WHOLE_DIGITS = 16;
  localparam int NUM_FRAC_DIGITS = 16;
  localparam int FP_WIDTH = NUM_WHOLE_DIGITS + NUM_FRAC_DIGITS;

  // enough bits to hold a count of 0 to FP_WIDTH
  localparam int LZ_WIDTH = $clog2(FP_WIDTH + 1);

  typedef logic signed [FP_WIDTH-1:0] fp;

  // 0.5 and 1.5 for the first guess and the Newton step
  localparam fp FP_HALF = 32'sh0000_8000;
  localparam fp FP_THREE_HALFS = 32'sh0001_8000;

  // sqrt(2) and 1/sqrt(2), rounded to 16 fraction bits
  localparam fp FP_SQRT_TWO = 32'sd92682;
  localparam fp FP_INV_SQRT_TWO = 32'sd46341;

  // slope of the chord through (0.5, sqrt2) and (1, 1)
  // about 0.828 in Q16.16
  localparam fp FP_INTERP_SLOPE = 32'sd54292;

  // full product then drop the low fraction bits
  function automatic fp fp_mul(fp a, fp b);
    logic signed [2*FP_WIDTH-1:0] prod;
    prod = a * b;
    // truncation toward minus infinity
    return prod[NUM_FRAC_DIGITS +: FP_WIDTH];
  endfunction

  function automatic fp fp_sub(fp a, fp b);
    return a - b;
  endfunction

  // counts zeros above the highest set bit
  // an all-zero word gives FP_WIDTH
  function automatic logic [LZ_WIDTH-1:0] fp_count_leading_zeros(fp a);
    logic [LZ_WIDTH-1:0] count;
    logic found;
    count = '0;
    found = 1'b0;
    for (int i = FP_WIDTH - 1; i >= 0; i--) begin
      if (!found) begin
        if (a[i]) begin
          found = 1'b1;
        end else begin
          count = count + 1'b1;
        end
      end
    end
    return count;
  endfunction

endpackage

// File: vec3_if.sv
`timescale 1ns/1ps

// three fp components plus a strobe
interface vec3_if import fp_pkg::*; ();

  // components in Q16.16
  fp x;
  fp y;
  fp z;

  // one-cycle pulse, components valid with it
  logic valid;

  // producer side
  modport src (
    output x,
    output y,
    output z,
    output valid
  );

  // consumer side
  modport dst (
    input x,
    input y,
    input z,
    input valid
  );

endinterface

// File: fp_dot3_folded.sv
`timescale 1ns/1ps

module fp_dot3_folded import fp_pkg::*; (
  input logic clk_in,
  input logic rst_in,
  vec3_if.dst vec_in,
  vec3_if.src vec_out,
  output fp sum_sq,
  output logic busy
);

  // 0 idle, 1..3 select x, y, z for the multiplier
  logic [1:0] stage;
  logic valid_q;

  // captured vector and running sum
  fp x_q;
  fp y_q;
  fp z_q;
  fp acc;

  // the one shared multiplier squares its operand
  fp mul_a;
  fp mul_res;

  always_comb begin
    case (stage)
      2'd2: mul_a = y_q;
      2'd3: mul_a = z_q;
      default: mul_a = x_q;
    endcase
  end

  assign mul_res = fp_mul(mul_a, mul_a);

  // stage sequencing
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      stage <= 2'd0;
      valid_q <= 1'b0;
    end else begin
      // strobe only on the last accumulate
      valid_q <= (stage == 2'd3);
      case (stage)
        2'd0: begin
          if (vec_in.valid) begin
            stage <= 2'd1;
          end
        end
        2'd3: stage <= 2'd0;
        default: stage <= stage + 2'd1;
      endcase
    end
  end

  // capture and accumulate
  always_ff @(posedge clk_in) begin
    case (stage)
      2'd0: begin
        if (vec_in.valid) begin
          x_q <= vec_in.x;
          y_q <= vec_in.y;
          z_q <= vec_in.z;
        end
      end
      // first product starts the sum
      2'd1: acc <= mul_res;
      default: acc <= acc + mul_res;
    endcase
  end

  // vector travels on with the sum for the scaling unit
  assign vec_out.x = x_q;
  assign vec_out.y = y_q;
  assign vec_out.z = z_q;
  assign vec_out.valid = valid_q;
  assign sum_sq = acc;

  // stays busy through the output cycle so ready can't blink high
  assign busy = (stage != 2'd0) || valid_q;

endmodule

// File: fp_inv_sqrt_folded.sv
`timescale 1ns/1ps

module fp_inv_sqrt_folded import fp_pkg::*; #(
  parameter int NEWTON_ITERS = 2
) (
  input logic clk_in,
  input logic rst_in,
  input fp a_in,
  input logic valid_in,
  output fp res_out,
  output logic valid_out,
  output logic ready_out
);

  localparam int ITER_W = $clog2(NEWTON_ITERS + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_NORM,
    S_GUESS,
    S_NEWTON,
    S_SHIFT
  } stage_t;

  stage_t stage;
  // Newton pass count and the multiply step inside a pass
  logic [ITER_W-1:0] iter;
  logic [1:0] step;

  // input, normalized in place to [0.5, 1)
  fp a_q;
  // current estimate and the x*x, a/2*x*x partial
  fp x_q;
  fp x_sq;

  // whole-part width that was shifted out
  logic [LZ_WIDTH-1:0] shift_amt;
  logic [LZ_WIDTH-1:0] shift_next;
  fp x_shifted;

  fp mul_a;
  fp mul_b;
  fp mul_res;

  assign shift_next = LZ_WIDTH'(NUM_WHOLE_DIGITS) - fp_count_leading_zeros(a_q);

  // undo half the normalization, odd leftover handled by 1/sqrt2
  assign x_shifted = x_q >>> (shift_amt >> 1);

  // operand steering for the one multiplier
  always_comb begin
    mul_a = '0;
    mul_b = '0;
    case (stage)
      S_GUESS: begin
        // slope * (a - 0.5)
        mul_a = FP_INTERP_SLOPE;
        mul_b = fp_sub(a_q, FP_HALF);
      end
      S_NEWTON: begin
        case (step)
          2'd0: begin
            mul_a = x_q;
            mul_b = x_q;
          end
          2'd1: begin
            mul_a = a_q >>> 1;
            mul_b = x_sq;
          end
          default: begin
            // x * (1.5 - a/2 * x*x)
            mul_a = x_q;
            mul_b = fp_sub(FP_THREE_HALFS, x_sq);
          end
        endcase
      end
      S_SHIFT: begin
        mul_a = x_shifted;
        mul_b = FP_INV_SQRT_TWO;
      end
      default: begin
        mul_a = '0;
        mul_b = '0;
      end
    endcase
  end

  assign mul_res = fp_mul(mul_a, mul_b);

  // control
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      stage <= S_IDLE;
      iter <= '0;
      step <= 2'd0;
      valid_out <= 1'b0;
      ready_out <= 1'b1;
    end else begin
      case (stage)
        S_IDLE: begin
          valid_out <= 1'b0;
          if (valid_in) begin
            ready_out <= 1'b0;
            stage <= S_NORM;
          end
        end
        S_NORM: stage <= S_GUESS;
        S_GUESS: begin
          iter <= '0;
          step <= 2'd0;
          stage <= S_NEWTON;
        end
        S_NEWTON: begin
          if (step == 2'd2) begin
            step <= 2'd0;
            iter <= iter + 1'b1;
            if (iter == ITER_W'(NEWTON_ITERS - 1)) begin
              stage <= S_SHIFT;
            end
          end else begin
            step <= step + 2'd1;
          end
        end
        S_SHIFT: begin
          // result and ready go out together
          valid_out <= 1'b1;
          ready_out <= 1'b1;
          stage <= S_IDLE;
        end
        default: stage <= S_IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk_in) begin
    case (stage)
      S_IDLE: begin
        if (valid_in) begin
          a_q <= a_in;
        end
      end
      S_NORM: begin
        shift_amt <= shift_next;
        a_q <= a_q >>> shift_next;
      end
      // chord approximation of 1/sqrt(a) on [0.5, 1)
      S_GUESS: x_q <= fp_sub(FP_SQRT_TWO, mul_res);
      S_NEWTON: begin
        if (step == 2'd2) begin
          x_q <= mul_res;
        end else begin
          x_sq <= mul_res;
        end
      end
      S_SHIFT: x_q <= shift_amt[0] ? mul_res : x_shifted;
      default: x_q <= x_q;
    endcase
  end

  assign res_out = x_q;

endmodule

// File: vec_scale_folded.sv
`timescale 1ns/1ps

module vec_scale_folded import fp_pkg::*; (
  input logic clk_in,
  input logic rst_in,
  vec3_if.dst vec_in,
  input fp inv_norm,
  input logic inv_norm_valid,
  output fp x_out,
  output fp y_out,
  output fp z_out,
  output logic valid_out,
  output logic busy
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_MUL_Y,
    S_MUL_Z
  } state_t;

  state_t state;

  // held vector and inverse norm
  fp x_q;
  fp y_q;
  fp z_q;
  fp norm_q;

  fp mul_a;
  fp mul_b;
  fp mul_res;

  // x goes straight through on the norm strobe, y and z use the latched copy
  always_comb begin
    case (state)
      S_MUL_Y: mul_a = y_q;
      S_MUL_Z: mul_a = z_q;
      default: mul_a = x_q;
    endcase
    mul_b = (state == S_WAIT) ? inv_norm : norm_q;
  end

  assign mul_res = fp_mul(mul_a, mul_b);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= S_IDLE;
      valid_out <= 1'b0;
    end else begin
      valid_out <= (state == S_MUL_Z);
      case (state)
        S_IDLE: begin
          if (vec_in.valid) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (inv_norm_valid) begin
            state <= S_MUL_Y;
          end
        end
        S_MUL_Y: state <= S_MUL_Z;
        default: state <= S_IDLE;
      endcase
    end
  end

  // payload
  always_ff @(posedge clk_in) begin
    if (state == S_IDLE && vec_in.valid) begin
      x_q <= vec_in.x;
      y_q <= vec_in.y;
      z_q <= vec_in.z;
    end
    if (state == S_WAIT && inv_norm_valid) begin
      norm_q <= inv_norm;
      x_out <= mul_res;
    end
    if (state == S_MUL_Y) begin
      y_out <= mul_res;
    end
    if (state == S_MUL_Z) begin
      z_out <= mul_res;
    end
  end

  assign busy = (state != S_IDLE);

endmodule

// File: vec_normalize.sv
`timescale 1ns/1ps

// unit vector of (x, y, z) in Q16.16
// one vector in flight, new input only while ready_out is high
module vec_normalize import fp_pkg::*; #(
  parameter int NEWTON_ITERS = 2
) (
  input logic clk_in,
  input logic rst_in,
  input fp x_in,
  input fp y_in,
  input fp z_in,
  input logic valid_in,
  output logic ready_out,
  output fp x_out,
  output fp y_out,
  output fp z_out,
  output logic valid_out
);

  // raw input and the vector handed from dot unit to scaler
  vec3_if in_vec ();
  vec3_if dot_vec ();

  fp sum_sq;
  fp inv_norm;
  logic inv_norm_valid;

  // idle indications of the three units
  logic dot_busy;
  logic inv_ready;
  logic scale_busy;

  // no queuing, so accept only when the whole chain is empty
  assign ready_out = !dot_busy && inv_ready && !scale_busy;

  assign in_vec.x = x_in;
  assign in_vec.y = y_in;
  assign in_vec.z = z_in;
  // strobes while busy are dropped here
  assign in_vec.valid = valid_in && ready_out;

  // x*x + y*y + z*z
  fp_dot3_folded dot_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .vec_in(in_vec.dst),
    .vec_out(dot_vec.src),
    .sum_sq(sum_sq),
    .busy(dot_busy)
  );

  // 1 / |v| from the squared length
  fp_inv_sqrt_folded #(
    .NEWTON_ITERS(NEWTON_ITERS)
  ) inv_sqrt_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .a_in(sum_sq),
    .valid_in(dot_vec.valid),
    .res_out(inv_norm),
    .valid_out(inv_norm_valid),
    .ready_out(inv_ready)
  );

  // v * (1 / |v|), one component per cycle
  vec_scale_folded scale_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .vec_in(dot_vec.dst),
    .inv_norm(inv_norm),
    .inv_norm_valid(inv_norm_valid),
    .x_out(x_out),
    .y_out(y_out),
    .z_out(z_out),
    .valid_out(valid_out),
    .busy(scale_busy)
  );

endmodule

// File: vec_normalize_properties.sv
`timescale 1ns/1ps

// handshake and latency checks on the top level ports
module vec_normalize_properties #(
  parameter int NEWTON_ITERS = 2
) (
  input logic clk_in,
  input logic rst_in,
  input logic valid_in,
  input logic ready_out,
  input logic valid_out
);

  localparam int LATENCY = 11 + 3 * NEWTON_ITERS;

  // vector in flight and edges since its accept
  logic in_flight;
  int age;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      in_flight <= 1'b0;
      age <= 0;
    end else if (valid_in && ready_out) begin
      in_flight <= 1'b1;
      age <= 1;
    end else if (valid_out) begin
      in_flight <= 1'b0;
    end else if (in_flight) begin
      age <= age + 1;
    end
  end

  a_reset_idle: assert property (@(posedge clk_in) rst_in |=> (ready_out && !valid_out))
    else $error("outputs not idle after reset");

  a_ready_low: assert property (@(posedge clk_in) disable iff (rst_in)
    (in_flight && !valid_out) |-> !ready_out)
    else $error("ready_out high while a vector is in flight");

  a_latency: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |-> (in_flight && age == LATENCY))
    else $error("valid_out at the wrong cycle");

  a_not_late: assert property (@(posedge clk_in) disable iff (rst_in)
    (in_flight && age == LATENCY) |-> valid_out)
    else $error("valid_out missing at the expected cycle");

  a_ready_with_valid: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |-> ready_out)
    else $error("ready_out did not rise with valid_out");

  a_pulse: assert property (@(posedge clk_in) disable iff (rst_in) valid_out |=> !valid_out)
    else $error("valid_out longer than one cycle");

endmodule

bind vec_normalize vec_normalize_properties #(
  .NEWTON_ITERS(NEWTON_ITERS)
) props_inst (
  .clk_in(clk_in),
  .rst_in(rst_in),
  .valid_in(valid_in),
  .ready_out(ready_out),
  .valid_out(valid_out)
);

// File: vec_normalize_tb.sv
`timescale 1ns/1ps

module vec_normalize_tb import fp_pkg::*; ();

  localparam int NEWTON_ITERS = 2;
  // accept edge to the edge that sees valid_out
  localparam int LATENCY = 11 + 3 * NEWTON_ITERS;
  localparam int TIMEOUT_CYCLES = 100;
  localparam int NUM_RANDOM = 300;
  localparam int unsigned SEED = 32'h103d81f0;
  // 2^-8 per component
  localparam real TOL = 1.0 / 256.0;

  logic clk_in;
  logic rst_in;
  fp x_in;
  fp y_in;
  fp z_in;
  logic valid_in;
  logic ready_out;
  fp x_out;
  fp y_out;
  fp z_out;
  logic valid_out;

  int fp_errors;
  int latency_errors;
  int flag_errors;
  int timeout_errors;

  vec_normalize #(
    .NEWTON_ITERS(NEWTON_ITERS)
  ) vec_normalize_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .x_in(x_in),
    .y_in(y_in),
    .z_in(z_in),
    .valid_in(valid_in),
    .ready_out(ready_out),
    .x_out(x_out),
    .y_out(y_out),
    .z_out(z_out),
    .valid_out(valid_out)
  );

  // 4 ns period
  always #2 clk_in = ~clk_in;

  function automatic real fp_to_real(input fp v);
    return $itor(v) / (2.0 ** NUM_FRAC_DIGITS);
  endfunction

  function automatic real sum_of_squares(input fp x, input fp y, input fp z);
    return fp_to_real(x) * fp_to_real(x) + fp_to_real(y) * fp_to_real(y)
      + fp_to_real(z) * fp_to_real(z);
  endfunction

  // uniform in [-span, span] raw lsbs
  function automatic fp random_component(input int unsigned span);
    return fp'(int'($urandom_range(2 * span, 0)) - int'(span));
  endfunction

  task automatic check_fp(input string name, input fp got, input real expected);
    real diff;
    diff = fp_to_real(got) - expected;
    if (diff > TOL || diff < -TOL) begin
      fp_errors++;
      $display("[ERROR] %0t: %s is %f, expected %f", $time, name, fp_to_real(got), expected);
    end
  endtask

  task automatic check_latency(input int got, input int expected);
    if (got != expected) begin
      latency_errors++;
      $display("[ERROR] %0t: latency is %0d cycles, expected %0d", $time, got, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      flag_errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, expected);
    end
  endtask

  // lengths spread over several scales, squared length in [1.01, 2^14)
  task automatic random_vector(output fp x, output fp y, output fp z);
    int unsigned span;
    real sq;
    int tries;
    tries = 0;
    do begin
      span = 32'd1 << (16 + 2 * $urandom_range(3, 0));
      x = random_component(span);
      y = random_component(span);
      z = random_component(span);
      sq = sum_of_squares(x, y, z);
      tries++;
    end while ((sq < 1.01 || sq >= 16384.0) && tries < 1000);
    // fallback if the draw never landed in range
    if (sq < 1.01 || sq >= 16384.0) begin
      x = 32'sh0001_0000;
      y = '0;
      z = '0;
    end
  endtask

  // called 1 ns after a rising edge
  // sends one vector, waits for its result and checks it
  task automatic run_vector(input fp x, input fp y, input fp z, input bit inject);
    real len;
    int cycles;
    bit seen;
    len = $sqrt(sum_of_squares(x, y, z));
    check_flag("ready_out before accept", ready_out, 1'b1);
    x_in = x;
    y_in = y;
    z_in = z;
    valid_in = 1'b1;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_in);
      #1;
      cycles++;
      if (valid_out) begin
        seen = 1'b1;
        check_flag("ready_out with valid_out", ready_out, 1'b1);
      end else begin
        check_flag("ready_out while busy", ready_out, 1'b0);
      end
      // junk strobes only while busy, the DUT must drop them
      if (inject && !ready_out) begin
        x_in = random_component(32'd1 << 20);
        y_in = random_component(32'd1 << 20);
        z_in = random_component(32'd1 << 20);
        valid_in = 1'($urandom_range(1, 0));
      end else begin
        valid_in = 1'b0;
      end
    end
    valid_in = 1'b0;
    if (!seen) begin
      timeout_errors++;
      $display("timeout: valid_out did not rise within %0d cycles at %0t", TIMEOUT_CYCLES,
        $time);
    end else begin
      check_latency(cycles, LATENCY);
      check_fp("x_out", x_out, fp_to_real(x) / len);
      check_fp("y_out", y_out, fp_to_real(y) / len);
      check_fp("z_out", z_out, fp_to_real(z) / len);
      // one-cycle pulse
      @(posedge clk_in);
      #1;
      check_flag("valid_out after pulse", valid_out, 1'b0);
    end
  endtask

  initial begin
    fp mag;
    fp rx;
    fp ry;
    fp rz;
    clk_in = 1'b0;
    rst_in = 1'b1;
    x_in = '0;
    y_in = '0;
    z_in = '0;
    valid_in = 1'b0;
    fp_errors = 0;
    latency_errors = 0;
    flag_errors = 0;
    timeout_errors = 0;
    void'($urandom(SEED));

    repeat (2) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    // idle after reset, nothing offered yet
    repeat (4) begin
      @(posedge clk_in);
      #1;
      check_flag("ready_out after reset", ready_out, 1'b1);
      check_flag("valid_out after reset", valid_out, 1'b0);
    end

    // each axis, both signs, magnitudes 1 to 100
    for (int m = 1; m <= 100; m++) begin
      mag = fp'(m <<< NUM_FRAC_DIGITS);
      run_vector(mag, '0, '0, 1'b0);
      run_vector(-mag, '0, '0, 1'b0);
      run_vector('0, mag, '0, 1'b0);
      run_vector('0, -mag, '0, 1'b0);
      run_vector('0, '0, mag, 1'b0);
      run_vector('0, '0, -mag, 1'b0);
    end

    // random vectors, every other one with junk strobes while busy
    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_vector(rx, ry, rz);
      run_vector(rx, ry, rz, 1'(i % 2));
    end

    $display("errors: value %0d, latency %0d, handshake %0d, timeout %0d", fp_errors,
      latency_errors, flag_errors, timeout_errors);
    if (fp_errors + latency_errors + flag_errors + timeout_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: compile.f
fp_pkg.sv
vec3_if.sv
fp_dot3_folded.sv
fp_inv_sqrt_folded.sv
vec_scale_folded.sv
vec_normalize.sv
vec_normalize_properties.sv
vec_normalize_tb.sv

// File: Makefile
# Verilator build and run for the vector normalizer testbench

VERILATOR ?= verilator
TOP ?= vec_normalize_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= ** PASS **
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qxF -- "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
